/* source/dma_settings.svh */
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// Memory bus geometry
`define DMA_DATA_BITS 16 // One data word
`define DMA_ADDR_BITS 16 // Word address, byte address is one bit wider

// Staging buffer between device and memory
`define DMA_FIFO_WORDS    8 // Also the longest transfer accepted
`define DMA_FIFO_PTR_BITS 3 // Slot index width

`endif

/* source/dma_mem_pkg.sv */
`include "dma_settings.svh"

package dma_mem_pkg;

	// Plain vectors of the bus fields
	typedef logic [`DMA_DATA_BITS-1:0] word_t;
	typedef logic [`DMA_ADDR_BITS-1:0] word_addr_t;
	typedef logic [`DMA_ADDR_BITS:0]   byte_addr_t; // As the device supplies it
	typedef logic [1:0]                mem_we_t;    // One enable per byte lane

	// ------------------------------------------------------------------------
	// Outgoing request toward the data memory
	// Held stable while en is high, until dma_ready
	// ------------------------------------------------------------------------
	typedef struct packed
	{
		logic       en;   // Access pending
		mem_we_t    we;   // 2'b11 on full-word writes only
		word_addr_t addr; // Word address
		word_t      data; // Write data, FIFO head
	} mem_req_t;

endpackage

/* source/dma_xfer_pkg.sv */
`include "dma_settings.svh"

package dma_xfer_pkg;

	typedef logic [`DMA_ADDR_BITS-1:0]     word_count_t; // Length or word index
	typedef logic [`DMA_FIFO_PTR_BITS-1:0] fifo_ptr_t;   // FIFO slot

	// Request as the device presents it with rqst
	typedef struct packed
	{
		word_count_t             num_words;  // Zero ends at once
		dma_mem_pkg::byte_addr_t start_addr; // Halved into a word address
		logic                    rd_wr;      // 1 memory to device, 0 device to memory
	} xfer_req_t;

	// Sequencer states
	typedef enum logic [2:0]
	{
		IDLE,        // Waiting for rqst
		GET_REGS,    // Request registered, length checked
		READ_MEM,    // Memory reads into FIFO
		SEND_TO_DEV, // FIFO out to device
		READ_DEV,    // Device words into FIFO
		SEND_TO_MEM, // FIFO out as memory writes
		END_XFER,    // end_flag pulse
		ERROR        // error_flag pulse
	} dma_state_t;

endpackage

/* source/dma_fifo.sv */
`timescale 1ns/1ps
`include "dma_settings.svh"

module dma_fifo
(
	input  logic               clk,
	input  logic               reset,
	input  logic               flush,    // Empty at transfer end or abort
	input  logic               push,
	input  logic               pop,
	input  logic               from_dev, // Write source select
	input  dma_mem_pkg::word_t dev_in,
	input  dma_mem_pkg::word_t dma_in,
	output dma_mem_pkg::word_t rd_data   // Head word
);

	dma_mem_pkg::word_t      mem [`DMA_FIFO_WORDS];
	dma_mem_pkg::word_t      wr_data;
	dma_xfer_pkg::fifo_ptr_t wr_ptr;
	dma_xfer_pkg::fifo_ptr_t rd_ptr;

	// Device side on writes, memory side on reads
	assign wr_data = from_dev ? dev_in : dma_in;

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= wr_data;
	end

	// ------------------------------------------------------------------------
	// Pointers
	// Transfers never exceed the depth, so no full or empty tracking
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else if (flush)
		begin
			wr_ptr <= '0; // Next transfer starts empty
			rd_ptr <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + dma_xfer_pkg::fifo_ptr_t'(1);
			if (pop)
				rd_ptr <= rd_ptr + dma_xfer_pkg::fifo_ptr_t'(1);
		end
	end

	// Head visible the cycle after its push
	assign rd_data = mem[rd_ptr];

endmodule

/* source/dma_addr_gen.sv */
`timescale 1ns/1ps
`include "dma_settings.svh"

module dma_addr_gen
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    load,      // Capture xfer
	input  logic                    advance,   // Next word
	input  logic                    clear,     // Index back to zero
	input  dma_xfer_pkg::xfer_req_t xfer,
	output dma_mem_pkg::word_addr_t mem_addr,
	output logic                    rd_wr,
	output logic                    last_word,
	output logic                    words_zero,
	output logic                    too_long
);

	dma_xfer_pkg::word_count_t num_words; // Registered length
	dma_xfer_pkg::word_count_t count;     // Word index within the phase
	dma_mem_pkg::word_addr_t   base_addr; // Start word address

	// Transfer registers
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			num_words <= '0;
			base_addr <= '0;
			rd_wr     <= 1'b0;
		end
		else if (load)
		begin
			num_words <= xfer.num_words;
			base_addr <= xfer.start_addr[`DMA_ADDR_BITS:1]; // Byte to word address
			rd_wr     <= xfer.rd_wr;
		end
	end

	// Word counter, clear wins over advance
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			count <= '0;
		else if (clear)
			count <= '0;
		else if (advance)
			count <= count + dma_xfer_pkg::word_count_t'(1);
	end

	assign mem_addr = base_addr + count; // Stays put until the access completes

	// Flags from the registers only
	assign last_word  = (count == num_words - dma_xfer_pkg::word_count_t'(1));
	assign words_zero = (num_words == '0);
	assign too_long   = (num_words > dma_xfer_pkg::word_count_t'(`DMA_FIFO_WORDS));

endmodule

/* source/dma_fsm.sv */
`timescale 1ns/1ps
`include "dma_settings.svh"

module dma_fsm
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 rqst,
	input  logic                 dev_ack,
	input  logic                 dma_ready,
	input  logic                 dma_resp,
	input  logic                 rd_wr,      // Registered direction
	input  logic                 last_word,
	input  logic                 words_zero,
	input  logic                 too_long,
	output logic                 load,
	output logic                 advance,
	output logic                 clear,
	output logic                 push,
	output logic                 pop,
	output logic                 flush,
	output logic                 from_dev,
	output logic                 mem_en,
	output dma_mem_pkg::mem_we_t mem_we,
	output logic                 dma_ack,
	output logic                 end_flag,
	output logic                 error_flag
);

	dma_xfer_pkg::dma_state_t state;
	dma_xfer_pkg::dma_state_t next_state;
	logic                     mem_ok;  // Access completed cleanly
	logic                     mem_err; // Access completed with a bus error

	assign mem_ok  = dma_ready & ~dma_resp;
	assign mem_err = dma_ready & dma_resp;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			state <= dma_xfer_pkg::IDLE;
		else
			state <= next_state;
	end

	// ------------------------------------------------------------------------
	// Next state and strobes
	// ------------------------------------------------------------------------
	always_comb
	begin
		next_state = state;
		load       = 1'b0;
		advance    = 1'b0;
		clear      = 1'b0;
		push       = 1'b0;
		pop        = 1'b0;
		flush      = 1'b0;
		from_dev   = 1'b0;
		mem_en     = 1'b0;
		mem_we     = 2'b00;
		dma_ack    = 1'b0;
		end_flag   = 1'b0;
		error_flag = 1'b0;

		case (state)
			dma_xfer_pkg::IDLE:
			begin
				clear = 1'b1; // Index zero for the first phase
				load  = rqst; // xfer valid with rqst
				if (rqst)
					next_state = dma_xfer_pkg::GET_REGS;
			end
			dma_xfer_pkg::GET_REGS:
			begin
				// Length checks before any bus access
				if (words_zero)
					next_state = dma_xfer_pkg::END_XFER;
				else if (too_long)
					next_state = dma_xfer_pkg::ERROR;
				else if (rd_wr)
					next_state = dma_xfer_pkg::READ_MEM;
				else
					next_state = dma_xfer_pkg::READ_DEV;
			end

			// Read: memory into FIFO, then FIFO to device
			dma_xfer_pkg::READ_MEM:
			begin
				mem_en = 1'b1; // Held through wait states
				if (mem_err)
					next_state = dma_xfer_pkg::ERROR;
				else if (mem_ok)
				begin
					push = 1'b1; // dma_in valid this cycle
					if (last_word)
					begin
						clear      = 1'b1; // Device phase counts from zero
						next_state = dma_xfer_pkg::SEND_TO_DEV;
					end
					else
						advance = 1'b1;
				end
			end
			dma_xfer_pkg::SEND_TO_DEV:
			begin
				if (dev_ack) // Low is back-pressure
				begin
					pop     = 1'b1;
					dma_ack = 1'b1; // dev_out holds the popped word
					advance = 1'b1;
					if (last_word)
						next_state = dma_xfer_pkg::END_XFER;
				end
			end

			// Write: device into FIFO, then FIFO to memory
			dma_xfer_pkg::READ_DEV:
			begin
				from_dev = 1'b1;
				if (dev_ack)
				begin
					push    = 1'b1;
					dma_ack = 1'b1;
					if (last_word)
					begin
						clear      = 1'b1;
						next_state = dma_xfer_pkg::SEND_TO_MEM;
					end
					else
						advance = 1'b1;
				end
			end
			dma_xfer_pkg::SEND_TO_MEM:
			begin
				mem_en = 1'b1;
				mem_we = 2'b11; // Full word
				if (mem_err)
					next_state = dma_xfer_pkg::ERROR;
				else if (mem_ok)
				begin
					pop     = 1'b1;
					advance = 1'b1;
					if (last_word)
						next_state = dma_xfer_pkg::END_XFER;
				end
			end

			dma_xfer_pkg::END_XFER:
			begin
				end_flag   = 1'b1;
				flush      = 1'b1;
				next_state = dma_xfer_pkg::IDLE;
			end
			dma_xfer_pkg::ERROR:
			begin
				error_flag = 1'b1;
				flush      = 1'b1; // Drop whatever was staged
				next_state = dma_xfer_pkg::IDLE;
			end
			default:
				next_state = dma_xfer_pkg::IDLE;
		endcase
	end

endmodule

/* source/dma_controller.sv */
`timescale 1ns/1ps
`include "dma_settings.svh"

module dma_controller
(
	input  logic                    clk,
	input  logic                    reset,
	// Device side
	input  logic                    rqst,
	input  dma_xfer_pkg::xfer_req_t xfer,
	input  logic                    dev_ack,
	input  dma_mem_pkg::word_t      dev_in,
	output logic                    dma_ack,
	output dma_mem_pkg::word_t      dev_out,
	output logic                    end_flag,
	output logic                    error_flag,
	// Memory side
	input  dma_mem_pkg::word_t      dma_in,
	input  logic                    dma_ready,
	input  logic                    dma_resp,
	output dma_mem_pkg::mem_req_t   dma_req
);

	logic                    load;
	logic                    advance;
	logic                    clear;
	logic                    push;
	logic                    pop;
	logic                    flush;
	logic                    from_dev;
	logic                    mem_en;
	dma_mem_pkg::mem_we_t    mem_we;
	logic                    rd_wr;
	logic                    last_word;
	logic                    words_zero;
	logic                    too_long;
	dma_mem_pkg::word_addr_t mem_addr;
	dma_mem_pkg::word_t      fifo_data; // FIFO head, shared by both sides

	// ------------------------------------------------------------------------
	// Sequencer, address generator and staging FIFO
	// ------------------------------------------------------------------------
	dma_fsm u_fsm
	(
		.clk        (clk),
		.reset      (reset),
		.rqst       (rqst),
		.dev_ack    (dev_ack),
		.dma_ready  (dma_ready),
		.dma_resp   (dma_resp),
		.rd_wr      (rd_wr),
		.last_word  (last_word),
		.words_zero (words_zero),
		.too_long   (too_long),
		.load       (load),
		.advance    (advance),
		.clear      (clear),
		.push       (push),
		.pop        (pop),
		.flush      (flush),
		.from_dev   (from_dev),
		.mem_en     (mem_en),
		.mem_we     (mem_we),
		.dma_ack    (dma_ack),
		.end_flag   (end_flag),
		.error_flag (error_flag)
	);

	dma_addr_gen u_addr_gen
	(
		.clk        (clk),
		.reset      (reset),
		.load       (load),
		.advance    (advance),
		.clear      (clear),
		.xfer       (xfer),
		.mem_addr   (mem_addr),
		.rd_wr      (rd_wr),
		.last_word  (last_word),
		.words_zero (words_zero),
		.too_long   (too_long)
	);

	dma_fifo u_fifo
	(
		.clk      (clk),
		.reset    (reset),
		.flush    (flush),
		.push     (push),
		.pop      (pop),
		.from_dev (from_dev),
		.dev_in   (dev_in),
		.dma_in   (dma_in),
		.rd_data  (fifo_data)
	);

	// Bus request from strobes, address and head word
	assign dma_req = '{en: mem_en, we: mem_we, addr: mem_addr, data: fifo_data};
	assign dev_out = fifo_data;

endmodule

/* bench/dma_controller_assert.sv */
`timescale 1ns/1ps

module dma_controller_assert
(
	input logic                  clk,
	input logic                  reset,
	input dma_mem_pkg::mem_req_t dma_req,
	input logic                  dev_ack,
	input logic                  dma_ack,
	input logic                  end_flag,
	input logic                  error_flag
);

	int failures = 0; // Summed up by the testbench at the end

	// ------------------------------------------------------------------------
	// Bus request shape
	// ------------------------------------------------------------------------
	we_needs_en: assert property (@(posedge clk) disable iff (reset)
		(dma_req.we != 2'b00) |-> dma_req.en)
	else
	begin
		failures++;
		$error("dma_req.we set while dma_req.en is low");
	end

	en_low_in_reset: assert property (@(posedge clk) reset |-> !dma_req.en)
	else
	begin
		failures++;
		$error("dma_req.en high during reset");
	end

	// ------------------------------------------------------------------------
	// Device side and end of transfer
	// ------------------------------------------------------------------------
	flags_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(end_flag && error_flag))
	else
	begin
		failures++;
		$error("end_flag and error_flag high in the same cycle");
	end

	ack_needs_dev_ack: assert property (@(posedge clk) disable iff (reset)
		dma_ack |-> dev_ack)
	else
	begin
		failures++;
		$error("dma_ack high without dev_ack");
	end

endmodule

/* bench/dma_controller_tb.sv */
`timescale 1ns/1ps
`include "dma_settings.svh"

module dma_controller_tb;

	localparam int XFER_TIMEOUT = 200; // Cycles allowed per transfer

	logic                    clk;
	logic                    reset;
	logic                    rqst;
	dma_xfer_pkg::xfer_req_t xfer;
	logic                    dev_ack;
	dma_mem_pkg::word_t      dev_in;
	logic                    dma_ack;
	dma_mem_pkg::word_t      dev_out;
	logic                    end_flag;
	logic                    error_flag;
	dma_mem_pkg::word_t      dma_in;
	logic                    dma_ready;
	logic                    dma_resp;
	dma_mem_pkg::mem_req_t   dma_req;

	// Memory model state
	dma_mem_pkg::word_t      mem_model [64];
	dma_mem_pkg::word_addr_t done_addrs [$]; // Clean completed accesses
	int                      access_count;
	int                      resp_at = 0;    // Access number that errors, 0 for none
	bit                      wait_states = 1'b0;
	int unsigned             lcg_state = 83;
	dma_mem_pkg::mem_we_t    exp_we = 2'b00; // Lane enables for the current direction

	// Monitor counts
	int                      end_pulses;
	int                      error_pulses;
	int                      ack_count;
	int                      en_cycles;
	dma_mem_pkg::word_t      rx_words [$];   // dev_out at each dma_ack

	// Per transfer snapshots and words sent by the device
	dma_mem_pkg::word_t      tx_words [$];
	int                      end_base;
	int                      error_base;
	int                      ack_base;
	int                      en_base;
	int                      done_base;
	int                      fail_count = 0;

	dma_controller DUT
	(
		.clk        (clk),
		.reset      (reset),
		.rqst       (rqst),
		.xfer       (xfer),
		.dev_ack    (dev_ack),
		.dev_in     (dev_in),
		.dma_ack    (dma_ack),
		.dev_out    (dev_out),
		.end_flag   (end_flag),
		.error_flag (error_flag),
		.dma_in     (dma_in),
		.dma_ready  (dma_ready),
		.dma_resp   (dma_resp),
		.dma_req    (dma_req)
	);

	bind dma_controller dma_controller_assert u_assert
	(
		.clk        (clk),
		.reset      (reset),
		.dma_req    (dma_req),
		.dev_ack    (dev_ack),
		.dma_ack    (dma_ack),
		.end_flag   (end_flag),
		.error_flag (error_flag)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	function automatic int unsigned next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;
	endfunction

	// ------------------------------------------------------------------------
	// Memory model, answers on the falling edge
	// ------------------------------------------------------------------------
	initial
	begin
		for (int i = 0; i < 64; i++)
			mem_model[6'(i)] = 16'h5A00 + dma_mem_pkg::word_t'(i * 37); // Address pattern
		access_count = 0;
		dma_ready    = 1'b0;
		dma_resp     = 1'b0;
		dma_in       = '0;
		forever
		begin
			@(negedge clk);
			dma_ready = 1'b0;
			dma_resp  = 1'b0;
			dma_in    = '0;
			if (dma_req.en)
			begin
				dma_in    = mem_model[dma_req.addr[5:0]]; // Read data with ready
				dma_ready = wait_states ? ((next_random() % 3) != 0) : 1'b1;
				if (dma_ready)
				begin
					compare_we("dma_req.we", dma_req.we, exp_we);
					access_count++;
					if (access_count == resp_at)
						dma_resp = 1'b1; // Injected bus error
					else
					begin
						done_addrs.push_back(dma_req.addr);
						if (dma_req.we == 2'b11)
							mem_model[dma_req.addr[5:0]] = dma_req.data;
					end
				end
			end
		end
	end

	// Output monitor, mid cycle after the inputs settle
	initial
	begin
		end_pulses   = 0;
		error_pulses = 0;
		ack_count    = 0;
		en_cycles    = 0;
		forever
		begin
			@(negedge clk);
			#10;
			if (end_flag)
				end_pulses++;
			if (error_flag)
				error_pulses++;
			if (dma_req.en)
				en_cycles++;
			if (dma_ack)
			begin
				ack_count++;
				rx_words.push_back(dev_out);
			end
		end
	end

	// ------------------------------------------------------------------------
	// Error reporting and compares
	// ------------------------------------------------------------------------
	task automatic stop_on_error(input string what);
		fail_count++;
		$display("%s", what);
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic compare_word(input string name, input dma_mem_pkg::word_t got,
		input dma_mem_pkg::word_t exp);
		if (got !== exp)
			stop_on_error($sformatf("Fail at %0t: %s is %h, expected %h",
				$time, name, got, exp));
	endtask

	task automatic verify_addr(input string name, input dma_mem_pkg::word_addr_t got,
		input dma_mem_pkg::word_addr_t exp);
		if (got !== exp)
			stop_on_error($sformatf("Fail at %0t: %s is %h, expected %h",
				$time, name, got, exp));
	endtask

	task automatic compare_we(input string name, input dma_mem_pkg::mem_we_t got,
		input dma_mem_pkg::mem_we_t exp);
		if (got !== exp)
			stop_on_error($sformatf("Fail at %0t: %s is %b, expected %b",
				$time, name, got, exp));
	endtask

	task automatic expect_bit(input string name, input bit got, input bit exp);
		if (got !== exp)
			stop_on_error($sformatf("Fail at %0t: %s is %b, expected %b",
				$time, name, got, exp));
	endtask

	// One transfer from rqst to its end or error pulse, entered on a falling edge
	task automatic do_transfer(input logic rd, input int byte_addr, input int n,
		input bit toggle, input int err_at);
		int cyc;
		int idx;
		end_base   = end_pulses;
		error_base = error_pulses;
		ack_base   = ack_count;
		en_base    = en_cycles;
		done_base  = done_addrs.size();
		resp_at    = (err_at > 0) ? access_count + err_at : 0;
		exp_we     = rd ? 2'b00 : 2'b11; // Full-word writes only
		rqst = 1'b1;
		xfer = '{num_words: dma_xfer_pkg::word_count_t'(n),
			start_addr: dma_mem_pkg::byte_addr_t'(byte_addr), rd_wr: rd};
		@(negedge clk);
		rqst = 1'b0;
		cyc  = 0;
		while (end_pulses == end_base && error_pulses == error_base)
		begin
			if (cyc == XFER_TIMEOUT)
				stop_on_error($sformatf("Transfer of %0d words did not end within %0d cycles",
					n, XFER_TIMEOUT));
			idx     = ack_count - ack_base; // Next word once the last was taken
			dev_in  = (idx < tx_words.size()) ? tx_words[idx] : '0;
			dev_ack = toggle ? cyc[0] : 1'b1;
			cyc++;
			@(negedge clk);
		end
		dev_ack = 1'b0;
		@(negedge clk); // A pulse longer than one cycle gets counted too
	endtask

	task automatic outcome(input bit ended, input bit errored);
		expect_bit("end_flag count", (end_pulses - end_base) == (ended ? 1 : 0), 1'b1);
		expect_bit("error_flag count", (error_pulses - error_base) == (errored ? 1 : 0), 1'b1);
	endtask

	task automatic consecutive_addrs(input int base, input int n);
		expect_bit("access count", (done_addrs.size() - done_base) == n, 1'b1);
		for (int i = 0; i < n; i++)
			verify_addr("dma_req.addr", done_addrs[done_base + i],
				dma_mem_pkg::word_addr_t'(base + i));
	endtask

	// ------------------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------------------
	task automatic write_block(input int byte_addr, input int n);
		int base;
		base = byte_addr / 2; // Word address
		tx_words.delete();
		for (int i = 0; i < n; i++)
			tx_words.push_back(dma_mem_pkg::word_t'(byte_addr * 256 + i * 4369 + 7));
		do_transfer(1'b0, byte_addr, n, 1'b0, 0);
		outcome(1'b1, 1'b0);
		for (int i = 0; i < n; i++)
			compare_word($sformatf("mem_model[%0d]", base + i), mem_model[6'(base + i)],
				tx_words[i]);
		consecutive_addrs(base, n);
	endtask

	task automatic read_block(input int byte_addr, input int n);
		int                 base;
		int                 rx0;
		dma_mem_pkg::word_t exp_words [$]; // Memory contents before the transfer
		base = byte_addr / 2;
		rx0  = rx_words.size();
		tx_words.delete();
		for (int i = 0; i < n; i++)
			exp_words.push_back(mem_model[6'(base + i)]);
		do_transfer(1'b1, byte_addr, n, 1'b1, 0); // dev_ack toggles
		outcome(1'b1, 1'b0);
		expect_bit("dev_out word count", (rx_words.size() - rx0) == n, 1'b1);
		for (int i = 0; i < n; i++)
			compare_word("dev_out", rx_words[rx0 + i], exp_words[i]);
		consecutive_addrs(base, n);
	endtask

	task automatic random_wait_run();
		wait_states = 1'b1;
		write_block(16'h22, 7);
		read_block(16'h22, 7); // Reads back what was just written
		wait_states = 1'b0;
	endtask

	task automatic bus_error_abort();
		tx_words.delete();
		for (int i = 0; i < 5; i++)
			tx_words.push_back(dma_mem_pkg::word_t'(16'h7100 + i));
		do_transfer(1'b0, 16'h60, 5, 1'b0, 3); // Third write errors
		outcome(1'b0, 1'b1);
		consecutive_addrs(16'h30, 2);
		read_block(16'h10, 4); // Normal read afterwards
	endtask

	task automatic length_limits();
		tx_words.delete();
		do_transfer(1'b1, 16'h20, 0, 1'b0, 0);
		outcome(1'b1, 1'b0);
		expect_bit("dma_req.en idle on zero length", en_cycles == en_base, 1'b1);
		do_transfer(1'b0, 16'h20, `DMA_FIFO_WORDS + 1, 1'b0, 0);
		outcome(1'b0, 1'b1);
		expect_bit("dma_req.en idle on overlong", en_cycles == en_base, 1'b1);
		expect_bit("dma_ack idle on overlong", ack_count == ack_base, 1'b1);
	endtask

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------
	initial
	begin
		reset   = 1'b1;
		rqst    = 1'b0;
		xfer    = '0;
		dev_ack = 1'b0;
		dev_in  = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);

		write_block(16'h10, 5);
		read_block(16'h40, 6);
		random_wait_run();
		bus_error_abort();
		length_limits();

		// Assertion failures count as well
		if (fail_count == 0 && DUT.u_assert.failures == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* dma_controller.f */
+incdir+source
source/dma_mem_pkg.sv
source/dma_xfer_pkg.sv
source/dma_fifo.sv
source/dma_addr_gen.sv
source/dma_fsm.sv
source/dma_controller.sv
bench/dma_controller_assert.sv
bench/dma_controller_tb.sv

/* Makefile */
# Verilator simulation of the DMA controller

TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
LINT      = --lint-only -Wall --timing
TOP       = dma_controller_tb
FILE_LIST = dma_controller.f
OBJ_DIR   = obj_dir
LOG       = sim.log
RUN_ARGS  = +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) -o V$(TOP)

# Pass only when the log holds the pass line
run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

lint:
	$(TOOL) $(LINT) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
